// ==== rmii_macros.svh ====
`ifndef RMII_MACROS_SVH
`define RMII_MACROS_SVH

//////////////////////////////
// RMII framing lengths

// Pair cycles for 7 preamble bytes plus the start byte
`define RMII_PREAMBLE_PAIRS 32

// Pair cycles for one full 32-bit word, also the FCS length
`define RMII_WORD_PAIRS 16

// Idle cycles after each frame, 12 byte times
`define RMII_IFG_CYCLES 48

//////////////////////////////
// Buffering

// Words held between the FPGA stream and the serializer
`define RMII_FIFO_DEPTH 8

`endif

// ==== rmii_pkg.sv ====
package rmii_pkg;

	//////////////////////////////
	// Word stream types

	// Byte count of a stream word, legal values 1 to 4
	typedef logic [2:0] byte_count_t;

	// One word of the FPGA-side transmit stream
	// First frame byte travels in data[31:24]
	typedef struct packed {
		logic [31:0]	data;
		// Fewer than 4 only allowed on the final word of a frame
		byte_count_t	bytes_valid;
		// Marks the final word of a frame
		logic			last;
	} tx_word_t;

	//////////////////////////////
	// Serializer states

	// IDLE      waiting for a queued word
	// PREAMBLE  seven 0x55 bytes then the 0xD5 start byte
	// DATA      frame bytes, one pair per clock
	// FCS       four CRC bytes, low byte first
	// GAP       inter-frame gap, also where discarded words get dropped
	typedef enum logic [2:0] {
		IDLE,
		PREAMBLE,
		DATA,
		FCS,
		GAP
	} tx_state_t;

endpackage

// ==== crc32_eth_x32.sv ====
`timescale 1ns/1ps

module crc32_eth_x32 import rmii_pkg::*; (
	input  logic		clk_50mhz,
	input  logic		rst,
	input  logic		crc_clear,
	input  logic		crc_en,
	input  logic [31:0]	crc_data,
	input  byte_count_t	crc_len,
	output logic [31:0]	crc_value
);

	// Reflected form of the 802.3 polynomial
	localparam logic [31:0] crc_poly = 32'hedb88320;

	// Running remainder, preset to all ones at frame start
	logic [31:0] remainder;

	// Remainder after each of the four byte lanes
	logic [31:0] stage [0:4];

	logic [31:0] folded;

	// One byte through the LFSR, bit 0 enters first
	function automatic logic [31:0] crc_byte(input logic [31:0] r, input logic [7:0] d);
		logic [31:0] c;
		c = r;
		for (int i = 0; i < 8; i++) begin
			if (c[0] ^ d[i])
				c = (c >> 1) ^ crc_poly;
			else
				c = c >> 1;
		end
		return c;
	endfunction

	//////////////////////////////
	// Unrolled byte network

	always_comb begin
		stage[0] = remainder;
		// Most significant byte is the earliest on the wire
		for (int k = 0; k < 4; k++)
			stage[k + 1] = crc_byte(stage[k], crc_data[31 - 8 * k -: 8]);

		// Pick the tap after crc_len bytes
		case (crc_len)
			3'd1:		folded = stage[1];
			3'd2:		folded = stage[2];
			3'd3:		folded = stage[3];
			3'd4:		folded = stage[4];
			default:	folded = stage[0];
		endcase
	end

	always_ff @(posedge clk_50mhz) begin
		if (rst)
			remainder <= '1;
		else if (crc_clear)
			remainder <= '1;
		else if (crc_en)
			remainder <= folded;
	end

	// Reflected remainder already puts the first FCS byte in [7:0]
	// and each byte LSB first, so only the final inversion is needed
	assign crc_value = ~remainder;

endmodule

// ==== tx_word_fifo.sv ====
`timescale 1ns/1ps

module tx_word_fifo import rmii_pkg::*; #(
	parameter int DEPTH = 8
) (
	input  logic		clk_50mhz,
	input  logic		rst,
	input  logic		push,
	input  tx_word_t	push_word,
	input  logic		pop,
	output tx_word_t	pop_word,
	output logic		full,
	output logic		empty
);

	localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int cnt_w = $clog2(DEPTH + 1);

	// Word storage
	tx_word_t mem [0:DEPTH-1];

	logic [ptr_w-1:0]	rd_ptr;
	logic [ptr_w-1:0]	wr_ptr;
	logic [cnt_w-1:0]	count;

	// Pointer advance with wrap for any depth
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		if (p == ptr_w'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	//////////////////////////////
	// Storage write

	always_ff @(posedge clk_50mhz) begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

	//////////////////////////////
	// Pointers and occupancy

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			rd_ptr	<= '0;
			wr_ptr	<= '0;
			count	<= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);

			// Simultaneous push and pop leave the count alone
			case ({push, pop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

	// Head word is visible without a pop
	assign pop_word	= mem[rd_ptr];
	assign full		= (count == cnt_w'(DEPTH));
	assign empty	= (count == '0);

	// Upstream wiring must hold off writes while full
	assert property (@(posedge clk_50mhz) disable iff (rst) push |-> !full);

	// Serializer must only take a word that exists
	assert property (@(posedge clk_50mhz) disable iff (rst) pop |-> !empty);

endmodule

// ==== rmii_tx_serializer.sv ====
`timescale 1ns/1ps
`include "rmii_macros.svh"

module rmii_tx_serializer import rmii_pkg::*; (
	input  logic		clk_50mhz,
	input  logic		rst,

	// Head of the word FIFO
	input  tx_word_t	fifo_word,
	input  logic		fifo_empty,
	output logic		fifo_pop,

	// CRC engine
	output logic		crc_clear,
	output logic		crc_en,
	output logic [31:0]	crc_data,
	output byte_count_t	crc_len,
	input  logic [31:0]	crc_value,

	// MCU side
	output logic		rmii_rx_en,
	output logic [1:0]	rmii_rxd,
	output logic		tx_underrun
);

	// Final count value of each phase
	localparam logic [5:0] pre_last = 6'(`RMII_PREAMBLE_PAIRS - 1);
	localparam logic [5:0] fcs_last = 6'(`RMII_WORD_PAIRS - 1);
	localparam logic [5:0] gap_last = 6'(`RMII_IFG_CYCLES - 1);

	tx_state_t	state;
	tx_state_t	state_nxt;

	// Counts pairs in PREAMBLE, DATA and FCS, idle cycles in GAP
	logic [5:0]	pair_cnt;
	logic [5:0]	pair_cnt_nxt;

	// Word being sent and the FCS latched at the end of data
	tx_word_t	cur_word;
	logic [31:0]	fcs_q;

	// Set after an underrun until the stalled frame's last word is gone
	logic		discard;
	logic		discard_nxt;

	logic		rx_en_nxt;
	logic [1:0]	rxd_nxt;
	logic		underrun_nxt;

	// Pop of a word for the frame versus a pop that throws it away
	logic		word_pop;
	logic		drop_pop;
	logic		load_fcs;
	logic		need_word;

	// Index of the last pair of the current word
	logic [5:0]	last_pair_idx;

	assign last_pair_idx = {1'b0, cur_word.bytes_valid, 2'b00} - 6'd1;

	//////////////////////////////
	// Next state and outputs

	always_comb begin
		state_nxt		= state;
		pair_cnt_nxt	= pair_cnt + 6'd1;
		discard_nxt		= discard;
		rx_en_nxt		= 1'b0;
		rxd_nxt			= 2'b00;
		underrun_nxt	= 1'b0;
		word_pop		= 1'b0;
		drop_pop		= 1'b0;
		crc_clear		= 1'b0;
		load_fcs		= 1'b0;
		need_word		= 1'b0;

		// Outside a frame, drop words left over from a truncated frame
		if ((state == IDLE || state == GAP) && discard && !fifo_empty) begin
			drop_pop = 1'b1;
			if (fifo_word.last)
				discard_nxt = 1'b0;
		end

		case (state)
			IDLE: begin
				pair_cnt_nxt = '0;
				if (!discard && !fifo_empty) begin
					state_nxt	= PREAMBLE;
					crc_clear	= 1'b1;
				end
			end

			PREAMBLE: begin
				rx_en_nxt = 1'b1;
				// 0x55 bytes, then 0xD5 whose final pair is 2'b11
				if (pair_cnt == pre_last) begin
					rxd_nxt		= 2'b11;
					need_word	= 1'b1;
				end else begin
					rxd_nxt		= 2'b01;
				end
			end

			DATA: begin
				rx_en_nxt	= 1'b1;
				// Byte lane from the top down, pair from bit 0 up
				rxd_nxt		= cur_word.data[{~pair_cnt[3:2], pair_cnt[1:0], 1'b0} +: 2];
				if (pair_cnt == last_pair_idx) begin
					if (cur_word.last) begin
						state_nxt		= FCS;
						pair_cnt_nxt	= '0;
						load_fcs		= 1'b1;
					end else begin
						need_word		= 1'b1;
					end
				end
			end

			FCS: begin
				rx_en_nxt	= 1'b1;
				rxd_nxt		= fcs_q[{pair_cnt[3:0], 1'b0} +: 2];
				if (pair_cnt == fcs_last) begin
					state_nxt		= GAP;
					pair_cnt_nxt	= '0;
				end
			end

			GAP: begin
				if (pair_cnt == gap_last) begin
					pair_cnt_nxt = '0;
					// Queued frame goes straight into its preamble
					if (!discard && !fifo_empty) begin
						state_nxt	= PREAMBLE;
						crc_clear	= 1'b1;
					end else begin
						state_nxt	= IDLE;
					end
				end
			end

			default: begin
				state_nxt		= IDLE;
				pair_cnt_nxt	= '0;
			end
		endcase

		// Next word wanted while the current last pair goes out
		if (need_word) begin
			pair_cnt_nxt = '0;
			if (fifo_empty) begin
				// Source fell behind, cut the frame with no FCS
				state_nxt		= GAP;
				underrun_nxt	= 1'b1;
				discard_nxt		= 1'b1;
			end else begin
				state_nxt		= DATA;
				word_pop		= 1'b1;
			end
		end
	end

	// CRC sees every word that enters the frame
	assign fifo_pop	= word_pop | drop_pop;
	assign crc_en	= word_pop;
	assign crc_data	= fifo_word.data;
	assign crc_len	= fifo_word.bytes_valid;

	//////////////////////////////
	// Registers

	always_ff @(posedge clk_50mhz) begin
		if (rst) begin
			state		<= IDLE;
			pair_cnt	<= '0;
			discard		<= 1'b0;
			rmii_rx_en	<= 1'b0;
			rmii_rxd	<= 2'b00;
			tx_underrun	<= 1'b0;
		end else begin
			state		<= state_nxt;
			pair_cnt	<= pair_cnt_nxt;
			discard		<= discard_nxt;
			rmii_rx_en	<= rx_en_nxt;
			rmii_rxd	<= rxd_nxt;
			tx_underrun	<= underrun_nxt;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (word_pop)
			cur_word <= fifo_word;
		// Last data word was folded in at least four cycles ago
		if (load_fcs)
			fcs_q <= crc_value;
	end

	// Only the first GAP cycle still carries the final pair of the frame
	assert property (@(posedge clk_50mhz) disable iff (rst)
		(state == IDLE || (state == GAP && pair_cnt != '0)) |-> !rmii_rx_en);

	// Source must present legal byte counts
	assert property (@(posedge clk_50mhz) disable iff (rst)
		word_pop |-> (fifo_word.bytes_valid inside {[3'd1:3'd4]}));

endmodule

// ==== rmii_mcu_bridge.sv ====
`timescale 1ns/1ps
`include "rmii_macros.svh"

module rmii_mcu_bridge import rmii_pkg::*; (
	input  logic		clk_50mhz,
	input  logic		rst,

	// FPGA-side word stream
	input  logic		tx_valid,
	input  logic [31:0]	tx_data,
	input  byte_count_t	tx_bytes_valid,
	input  logic		tx_last,
	output logic		tx_ready,

	// MCU RMII receive port
	output logic		rmii_rx_en,
	output logic [1:0]	rmii_rxd,
	output logic		tx_underrun
);

	tx_word_t		in_word;
	tx_word_t		fifo_word;
	logic			fifo_full;
	logic			fifo_empty;
	logic			fifo_pop;

	logic			crc_clear;
	logic			crc_en;
	logic [31:0]	crc_data;
	byte_count_t	crc_len;
	logic [31:0]	crc_value;

	assign in_word	= '{data: tx_data, bytes_valid: tx_bytes_valid, last: tx_last};
	assign tx_ready	= !fifo_full;

	//////////////////////////////
	// Word buffer

	tx_word_fifo #(
		.DEPTH		(`RMII_FIFO_DEPTH)
	) i_fifo (
		.clk_50mhz	(clk_50mhz),
		.rst		(rst),
		// Accept on valid and ready
		.push		(tx_valid && !fifo_full),
		.push_word	(in_word),
		.pop		(fifo_pop),
		.pop_word	(fifo_word),
		.full		(fifo_full),
		.empty		(fifo_empty)
	);

	//////////////////////////////
	// Framing and FCS

	rmii_tx_serializer i_serializer (
		.clk_50mhz	(clk_50mhz),
		.rst		(rst),
		.fifo_word	(fifo_word),
		.fifo_empty	(fifo_empty),
		.fifo_pop	(fifo_pop),
		.crc_clear	(crc_clear),
		.crc_en		(crc_en),
		.crc_data	(crc_data),
		.crc_len	(crc_len),
		.crc_value	(crc_value),
		.rmii_rx_en	(rmii_rx_en),
		.rmii_rxd	(rmii_rxd),
		.tx_underrun	(tx_underrun)
	);

	crc32_eth_x32 i_crc (
		.clk_50mhz	(clk_50mhz),
		.rst		(rst),
		.crc_clear	(crc_clear),
		.crc_en		(crc_en),
		.crc_data	(crc_data),
		.crc_len	(crc_len),
		.crc_value	(crc_value)
	);

endmodule

// ==== tb_rmii_mcu_bridge.sv ====
`timescale 1ns/1ps
`include "rmii_macros.svh"

module tb_rmii_mcu_bridge import rmii_pkg::*; ();

	// Frame sizes used below, for the watchdog budget
	localparam int total_bytes = 60 + 64 + 4 * 100 + 64 + 61 + 64 + 60;
	localparam int n_frames = 10;
	localparam int limit_cycles = total_bytes * 4 +
		n_frames * (`RMII_PREAMBLE_PAIRS + `RMII_WORD_PAIRS + `RMII_IFG_CYCLES) + 1000;

	logic			clk_50mhz;
	logic			rst;
	logic			tx_valid;
	logic [31:0]	tx_data;
	byte_count_t	tx_bytes_valid;
	logic			tx_last;
	logic			tx_ready;
	logic			rmii_rx_en;
	logic [1:0]		rmii_rxd;
	logic			tx_underrun;

	int errors = 0;
	int checks = 0;
	logic [31:0] seed = 32'hd454;

	// Frame under construction, expected wire bytes and captured wire bytes
	logic [7:0] frame_q[$];
	logic [7:0] exp_q[$];
	int exp_len_q[$];
	logic [7:0] cap_q[$];
	int cap_len_q[$];
	int frames_expected = 0;
	int frames_done = 0;

	// Line monitor state
	logic rx_en_q = 1'b0;
	logic [7:0] shift = '0;
	int hi_cnt = 0;
	int low_cnt = 0;
	int n_bytes = 0;
	int last_hi = 0;
	int last_gap = 0;
	int underrun_cnt = 0;

	// Source-side bookkeeping for back-pressure
	int words_accepted = 0;
	int first_stall_at = -1;

	rmii_mcu_bridge i_dut (
		.clk_50mhz		(clk_50mhz),
		.rst			(rst),
		.tx_valid		(tx_valid),
		.tx_data		(tx_data),
		.tx_bytes_valid	(tx_bytes_valid),
		.tx_last		(tx_last),
		.tx_ready		(tx_ready),
		.rmii_rx_en		(rmii_rx_en),
		.rmii_rxd		(rmii_rxd),
		.tx_underrun	(tx_underrun)
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	//////////////////////////////
	// Reference model

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 802.3 FCS one bit at a time, LSB of each byte first
	function automatic logic [31:0] fcs_of(input int n);
		logic [31:0] r;
		logic fb;
		r = 32'hffffffff;
		for (int i = 0; i < n; i++) begin
			for (int b = 0; b < 8; b++) begin
				fb = r[0] ^ frame_q[i][b];
				r = r >> 1;
				if (fb)
					r = r ^ 32'hedb88320;
			end
		end
		return ~r;
	endfunction

	function automatic logic [7:0] byte_at(input int i);
		if (i < frame_q.size())
			return frame_q[i];
		return 8'h00;
	endfunction

	task automatic make_frame(input int n);
		frame_q.delete();
		for (int i = 0; i < n; i++) begin
			seed = xorshift(seed);
			frame_q.push_back(seed[7:0]);
		end
	endtask

	// Wire bytes for the first n_data frame bytes, FCS low byte first
	task automatic expect_frame(input int n_data, input bit with_fcs);
		logic [31:0] fcs;
		fcs = fcs_of(n_data);
		repeat (7) exp_q.push_back(8'h55);
		exp_q.push_back(8'hd5);
		for (int i = 0; i < n_data; i++)
			exp_q.push_back(frame_q[i]);
		if (with_fcs) begin
			for (int k = 0; k < 4; k++)
				exp_q.push_back(fcs[8 * k +: 8]);
		end
		exp_len_q.push_back(8 + n_data + (with_fcs ? 4 : 0));
		frames_expected++;
	endtask

	//////////////////////////////
	// Source driver

	// Called 2 ns after a rising edge, returns at the same point
	task automatic put_word(input int w);
		int n;
		n = frame_q.size() - 4 * w;
		tx_data = {byte_at(4 * w), byte_at(4 * w + 1), byte_at(4 * w + 2), byte_at(4 * w + 3)};
		tx_bytes_valid = byte_count_t'((n > 4) ? 4 : n);
		tx_last = (n <= 4);
		tx_valid = 1'b1;
		// tx_ready is settled mid-cycle
		@(negedge clk_50mhz);
		while (!tx_ready) begin
			if (first_stall_at < 0)
				first_stall_at = words_accepted;
			@(negedge clk_50mhz);
		end
		@(posedge clk_50mhz);
		words_accepted++;
		#2;
		tx_valid = 1'b0;
	endtask

	task automatic send_words(input int first, input int last_w);
		for (int w = first; w <= last_w; w++)
			put_word(w);
	endtask

	task automatic wait_frames();
		wait (frames_done == frames_expected);
		@(posedge clk_50mhz);
		#2;
	endtask

	// Edges from the accepting edge until rmii_rx_en is seen high
	task automatic measure_latency(output int n);
		@(negedge clk_50mhz);
		while (!(tx_valid && tx_ready))
			@(negedge clk_50mhz);
		@(posedge clk_50mhz);
		n = 0;
		do begin
			@(posedge clk_50mhz);
			n++;
			@(negedge clk_50mhz);
		end while (!rmii_rx_en && n < 10);
	endtask

	//////////////////////////////
	// Line monitor

	// Mid-cycle sampling, pairs arrive low pair first
	always @(negedge clk_50mhz) begin
		if (tx_underrun)
			underrun_cnt++;
		if (rmii_rx_en) begin
			if (!rx_en_q) begin
				last_gap = low_cnt;
				hi_cnt = 0;
				n_bytes = 0;
			end
			shift = {rmii_rxd, shift[7:2]};
			hi_cnt++;
			if (hi_cnt % 4 == 0) begin
				cap_q.push_back(shift);
				n_bytes++;
			end
		end else begin
			if (rx_en_q) begin
				last_hi = hi_cnt;
				cap_len_q.push_back(n_bytes);
				frames_done++;
				low_cnt = 0;
			end
			low_cnt++;
		end
		rx_en_q = rmii_rx_en;
	end

	//////////////////////////////
	// Compare tasks

	task automatic compare_bytes(input string what);
		int n_exp;
		int n_got;
		logic [7:0] e;
		logic [7:0] g;
		bit bad;
		checks++;
		if (cap_len_q.size() == 0 || exp_len_q.size() == 0) begin
			errors++;
			$display("no frame was captured for %s", what);
			return;
		end
		n_exp = exp_len_q.pop_front();
		n_got = cap_len_q.pop_front();
		bad = (n_got != n_exp);
		if (bad) begin
			errors++;
			$display("mismatch at %0t: %s is %0d bytes, expected %0d", $time, what, n_got, n_exp);
		end
		for (int i = 0; i < n_exp || i < n_got; i++) begin
			e = 8'h00;
			g = 8'h00;
			if (i < n_exp)
				e = exp_q.pop_front();
			if (i < n_got)
				g = cap_q.pop_front();
			if (!bad && e != g) begin
				bad = 1'b1;
				errors++;
				$display("mismatch at %0t: %s byte %0d is %02h, expected %02h",
					$time, what, i, g, e);
			end
		end
	endtask

	task automatic flag_is(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic count_is(input string what, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// Directed tests

	task automatic reset_and_latency();
		int lat;
		@(negedge clk_50mhz);
		flag_is("rmii_rx_en after reset", rmii_rx_en, 1'b0);
		flag_is("tx_underrun after reset", tx_underrun, 1'b0);
		flag_is("rmii_rxd[0] after reset", rmii_rxd[0], 1'b0);
		flag_is("rmii_rxd[1] after reset", rmii_rxd[1], 1'b0);
		flag_is("tx_ready after reset", tx_ready, 1'b1);
		@(posedge clk_50mhz);
		#2;
		make_frame(60);
		expect_frame(60, 1'b1);
		fork
			send_words(0, 14);
			measure_latency(lat);
		join
		wait_frames();
		count_is("cycles from accept to rmii_rx_en", lat, 2);
		compare_bytes("first frame");
	endtask

	task automatic single_frame();
		make_frame(64);
		expect_frame(64, 1'b1);
		send_words(0, 15);
		wait_frames();
		compare_bytes("64-byte frame");
		count_is("rmii_rx_en high cycles", last_hi,
			`RMII_PREAMBLE_PAIRS + 4 * 64 + `RMII_WORD_PAIRS);
	endtask

	// k sets the byte count of the last word
	task automatic random_lengths();
		int n;
		for (int k = 1; k <= 4; k++) begin
			seed = xorshift(seed);
			n = 4 * (15 + seed % 10) + k;
			make_frame(n);
			expect_frame(n, 1'b1);
			send_words(0, (n - 1) / 4);
			wait_frames();
			compare_bytes($sformatf("%0d-byte frame", n));
		end
	endtask

	task automatic back_to_back();
		words_accepted = 0;
		first_stall_at = -1;
		make_frame(64);
		expect_frame(64, 1'b1);
		send_words(0, 15);
		make_frame(61);
		expect_frame(61, 1'b1);
		send_words(0, 15);
		wait_frames();
		count_is("words queued before tx_ready fell", first_stall_at, `RMII_FIFO_DEPTH);
		compare_bytes("back-to-back frame A");
		compare_bytes("back-to-back frame B");
		count_is("inter-frame gap cycles", last_gap, `RMII_IFG_CYCLES);
	endtask

	// Three words then a stall, rest of the frame arrives late
	task automatic underrun_recovery();
		make_frame(64);
		expect_frame(12, 1'b0);
		send_words(0, 2);
		wait_frames();
		count_is("underrun pulse cycles", underrun_cnt, 1);
		count_is("truncated frame high cycles", last_hi, `RMII_PREAMBLE_PAIRS + 48);
		compare_bytes("truncated frame");
		send_words(3, 15);
		make_frame(60);
		expect_frame(60, 1'b1);
		send_words(0, 14);
		wait_frames();
		compare_bytes("frame after underrun");
		count_is("total underrun cycles", underrun_cnt, 1);
	endtask

	//////////////////////////////
	// Run control

	initial begin
		rst = 1'b1;
		tx_valid = 1'b0;
		tx_data = '0;
		tx_bytes_valid = '0;
		tx_last = 1'b0;
		repeat (5) @(posedge clk_50mhz);
		#2;
		rst = 1'b0;
		reset_and_latency();
		single_frame();
		random_lengths();
		back_to_back();
		underrun_recovery();
		repeat (4) @(posedge clk_50mhz);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin : watchdog
		tx_state_t st;
		#(limit_cycles * 20);
		st = i_dut.i_serializer.state;
		$display("run timed out, serializer in state %s", st.name());
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
rmii_pkg.sv
crc32_eth_x32.sv
tx_word_fifo.sv
rmii_tx_serializer.sv
rmii_mcu_bridge.sv
tb_rmii_mcu_bridge.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rmii_mcu_bridge
RTL_TOP ?= rmii_mcu_bridge
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= CHECKS FAILED
VFLAGS ?= --timing
LINT_FLAGS ?= -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
